// File: iagc.f
+incdir+hw
hw/iagc_pkg.sv
hw/adc_front.sv
hw/amplitude_detector.sv
hw/phase_detector.sv
hw/report_framer.sv
hw/report_arbiter.sv
hw/uart_tx.sv
hw/iagc_top.sv
tests/iagc_properties.sv
tests/iagc_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, verdict taken from the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f iagc.f --top-module iagc_tb \
  -Mdir obj_dir -o iagc_sim > build.log 2>&1 \
  && ./obj_dir/iagc_sim > sim.log 2>&1 ; \
grep -q "All tests passed" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see build.log and sim.log"; exit 1; }

// File: tests/iagc_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "iagc_settings.svh"

module iagc_tb;
  import iagc_pkg::*;

  localparam int WINDOW   = 16;
  localparam int BIT_CLKS = 8;
  localparam int N_ROWS   = 6;
  // 5 amplitude frame bytes and 3 phase frame bytes
  localparam int N_RX     = 8;
  // cycles allowed for any one wait
  localparam int TIMEOUT  = 400;

  // one window of stimulus
  typedef struct packed {
    logic [15:0] ref_base;
    logic [15:0] err_base;
    // bit set flips err sign against ref
    logic [15:0] sign_pat;
    // ungated samples ahead of the window
    logic [7:0]  gate_off;
  } row_t;

  logic        clock;
  logic        arst_n;
  logic [31:0] adc_data;
  logic        adc_data_valid;
  logic        gate;
  logic        tx;

  row_t        rows [N_ROWS];
  logic [7:0]  rx [N_RX];
  logic [15:0] ref_smp [WINDOW];
  logic [15:0] err_smp [WINDOW];
  integer      seed;
  int          n_checks;
  int          n_errors;

  iagc_top #(
    .P_AMPLITUDE_COUNT(WINDOW),
    .P_PHASE_COUNT    (WINDOW),
    .P_CLKS_PER_BIT   (BIT_CLKS)
  ) uut (
    .i_clock         (clock),
    .i_arst_n        (arst_n),
    .i_adc_data      (adc_data),
    .i_adc_data_valid(adc_data_valid),
    .i_gate          (gate),
    .o_tx            (tx)
  );

  initial clock = 1'b0;
  always #50 clock = ~clock;

  // closing summary and stop
  task automatic end_run();
    $display("checks %0d errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    assert (got === exp) else begin
      n_errors++;
      $display("Fail %s got %h expected %h", name, got, exp);
    end
  endtask

  // expected magnitude with the most negative value clipped to 7fff
  function automatic logic [15:0] abs_sat(input logic [15:0] v);
    if (v == 16'h8000) begin
      return 16'h7FFF;
    end else if (v[15]) begin
      return 16'h0000 - v;
    end
    return v;
  endfunction

  // one clock of inputs while the serial line stays quiet
  task automatic drive_cycle(input logic strobe, input logic [31:0] word, input logic g);
    @(posedge clock);
    #10;
    adc_data_valid = strobe;
    adc_data       = word;
    gate           = g;
    check_value("o_tx", 32'(tx), 32'd1);
  endtask

  // mid-bit sampling on the falling edge
  task automatic receive_byte(output logic [7:0] data);
    int wait_cnt;
    int i;
    wait_cnt = 0;
    while (tx !== 1'b0 && wait_cnt <= TIMEOUT) begin
      @(negedge clock);
      wait_cnt++;
    end
    if (wait_cnt > TIMEOUT) begin
      n_errors++;
      $display("timed out waiting for a start bit on o_tx");
      end_run();
    end else begin
      // middle of the start bit
      repeat (BIT_CLKS / 2 - 1) @(negedge clock);
      check_value("o_tx start bit", 32'(tx), 32'd0);
      for (i = 0; i < 8; i++) begin
        repeat (BIT_CLKS) @(negedge clock);
        data[i] = tx;
      end
      repeat (BIT_CLKS) @(negedge clock);
      check_value("o_tx stop bit", 32'(tx), 32'd1);
    end
  endtask

  task automatic apply_window(input row_t row);
    int i;
    // gate low long enough to clear the synchronizer
    for (i = 0; i < 3; i++) drive_cycle(1'b0, 32'd0, 1'b0);
    // full negative scale on both channels is ignored
    for (i = 0; i < int'(row.gate_off); i++) drive_cycle(1'b1, 32'h8000_8000, 1'b0);
    for (i = 0; i < 3; i++) drive_cycle(1'b0, 32'd0, 1'b1);
    for (i = 0; i < WINDOW; i++) drive_cycle(1'b1, {ref_smp[i], err_smp[i]}, 1'b1);
    drive_cycle(1'b0, 32'd0, 1'b1);
  endtask

  initial begin
    int          r;
    int          i;
    int          jit;
    int          agree;
    logic [15:0] mag;
    logic [15:0] exp_ref;
    logic [15:0] exp_err;
    logic        neg;
    logic        exp_in_phase;
    seed           = 38;
    n_checks       = 0;
    n_errors       = 0;
    arst_n         = 1'b0;
    adc_data       = 32'd0;
    adc_data_valid = 1'b0;
    gate           = 1'b0;
    // ref, err, sign flips, ungated lead-in
    rows[0] = '{16'h7FFF, 16'h7FF8, 16'h0000, 8'd0};
    rows[1] = '{16'h8000, 16'h1234, 16'hFFFF, 8'd3};
    rows[2] = '{16'h0400, 16'h0100, 16'h00F0, 8'd0};
    rows[3] = '{16'hF000, 16'h0200, 16'h0F0F, 8'd0};
    rows[4] = '{16'h0123, 16'h0050, 16'h0001, 8'd10};
    rows[5] = '{16'h0000, 16'h0010, 16'h8001, 8'd2};
    repeat (4) @(posedge clock);
    #10;
    arst_n = 1'b1;
    // quiet line after reset
    for (i = 0; i < 200; i++) drive_cycle(1'b0, 32'd0, 1'b0);
    for (r = 0; r < N_ROWS; r++) begin
      exp_ref = 16'd0;
      exp_err = 16'd0;
      agree   = 0;
      for (i = 0; i < WINDOW; i++) begin
        jit        = int'($unsigned($random(seed)) % 32'd8);
        mag        = rows[r].err_base - 16'(jit);
        neg        = rows[r].ref_base[15] ^ rows[r].sign_pat[i];
        ref_smp[i] = rows[r].ref_base;
        err_smp[i] = neg ? 16'h0000 - mag : mag;
        if (abs_sat(ref_smp[i]) > exp_ref) begin
          exp_ref = abs_sat(ref_smp[i]);
        end
        if (abs_sat(err_smp[i]) > exp_err) begin
          exp_err = abs_sat(err_smp[i]);
        end
        // zero has a clear sign bit and counts as positive
        if (ref_smp[i][15] == err_smp[i][15]) begin
          agree++;
        end
      end
      exp_in_phase = (4 * agree) >= (3 * WINDOW);
      apply_window(rows[r]);
      for (i = 0; i < N_RX; i++) receive_byte(rx[i]);
      // whole amplitude frame before the whole phase frame
      check_value("amplitude header", 32'(rx[0]), 32'(`IAGC_AMPLITUDE_HEADER));
      check_value("ref_peak", 32'({rx[1], rx[2]}), 32'(exp_ref));
      check_value("err_peak", 32'({rx[3], rx[4]}), 32'(exp_err));
      check_value("phase header", 32'(rx[5]), 32'(`IAGC_PHASE_HEADER));
      check_value("in_phase", 32'(rx[6][7]), 32'(exp_in_phase));
      check_value("agree_count", 32'({rx[6][6:0], rx[7]}), 32'(agree));
    end
    end_run();
  end

endmodule

`default_nettype wire

// File: tests/iagc_properties.sv
`timescale 1ns/100ps
`default_nettype none

`include "iagc_settings.svh"

module iagc_properties (
  input logic                    i_clock,
  input logic                    i_arst_n,
  input logic                    i_amp_valid,
  input logic                    i_amp_last,
  input logic                    i_phase_valid,
  input logic                    i_phase_last,
  input logic                    i_tx_valid,
  input logic [`IAGC_BYTE_W-1:0] i_tx_data,
  input logic                    i_tx_ready,
  input logic                    i_amp_ready,
  input logic                    i_phase_ready
);

  // byte leaving each framer
  logic amp_xfer;
  logic phase_xfer;
  // frame started and not yet closed by its last byte
  logic in_frame;
  // set while the open frame is a phase frame
  logic frame_phase;

  assign amp_xfer   = i_amp_valid & i_amp_ready;
  assign phase_xfer = i_phase_valid & i_phase_ready;

  // frame tracking from the framer handshakes
  always_ff @(posedge i_clock or negedge i_arst_n) begin
    if (!i_arst_n) begin
      in_frame    <= 1'b0;
      frame_phase <= 1'b0;
    end else if (amp_xfer) begin
      in_frame    <= ~i_amp_last;
      frame_phase <= 1'b0;
    end else if (phase_xfer) begin
      in_frame    <= ~i_phase_last;
      frame_phase <= 1'b1;
    end
  end

  // no ready to the other framer until the last byte moves
  grant_hold: assert property (@(posedge i_clock) disable iff (!i_arst_n)
    in_frame |-> !(frame_phase ? i_amp_ready : i_phase_ready)
  ) else $error("grant changed in the middle of a frame");

  // stalled byte keeps its value
  data_hold: assert property (@(posedge i_clock) disable iff (!i_arst_n)
    (i_tx_valid && !i_tx_ready) |=> $stable(i_tx_data)
  ) else $error("tx data changed while stalled");

  // one framer at most sees ready and every tx byte comes from one framer
  ready_onehot: assert property (@(posedge i_clock) disable iff (!i_arst_n)
    !(i_amp_ready && i_phase_ready) &&
    ((i_tx_valid && i_tx_ready) == (amp_xfer || phase_xfer))
  ) else $error("framer handshakes do not match the tx handshake");

endmodule

bind report_arbiter iagc_properties u_properties (
  .i_clock      (i_clock),
  .i_arst_n     (i_arst_n),
  .i_amp_valid  (i_amp_stream.valid),
  .i_amp_last   (i_amp_stream.last),
  .i_phase_valid(i_phase_stream.valid),
  .i_phase_last (i_phase_stream.last),
  .i_tx_valid   (o_tx_valid),
  .i_tx_data    (o_tx_data),
  .i_tx_ready   (i_tx_ready),
  .i_amp_ready  (o_amp_ready),
  .i_phase_ready(o_phase_ready)
);

`default_nettype wire

// File: hw/iagc_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "iagc_settings.svh"

module iagc_top #(
  parameter int P_AMPLITUDE_COUNT = `IAGC_AMPLITUDE_COUNT,
  parameter int P_PHASE_COUNT     = `IAGC_PHASE_COUNT,
  parameter int P_CLKS_PER_BIT    = `IAGC_CLKS_PER_BIT
) (
  input  logic                    i_clock,
  input  logic                    i_arst_n,
  input  logic [`IAGC_WORD_W-1:0] i_adc_data,
  input  logic                    i_adc_data_valid,
  input  logic                    i_gate,
  output logic                    o_tx
);
  import iagc_pkg::*;

  // gated samples to both detectors
  sample_t                 sample;
  // detector reports
  amplitude_report_t       amp_report;
  logic                    amp_report_valid;
  phase_report_t           phase_report;
  logic                    phase_report_valid;
  // framed byte streams
  byte_stream_t            amp_stream;
  byte_stream_t            phase_stream;
  logic                    amp_ready;
  logic                    phase_ready;
  // arbiter to transmitter
  logic                    tx_valid;
  logic [`IAGC_BYTE_W-1:0] tx_data;
  logic                    tx_ready;

  adc_front u_adc_front (
    .i_clock         (i_clock),
    .i_arst_n        (i_arst_n),
    .i_adc_data      (i_adc_data),
    .i_adc_data_valid(i_adc_data_valid),
    .i_gate          (i_gate),
    .o_sample        (sample)
  );

  amplitude_detector #(
    .P_COUNT(P_AMPLITUDE_COUNT)
  ) u_amplitude_detector (
    .i_clock       (i_clock),
    .i_arst_n      (i_arst_n),
    .i_sample      (sample),
    .o_report      (amp_report),
    .o_report_valid(amp_report_valid)
  );

  phase_detector #(
    .P_COUNT(P_PHASE_COUNT)
  ) u_phase_detector (
    .i_clock       (i_clock),
    .i_arst_n      (i_arst_n),
    .i_sample      (sample),
    .o_report      (phase_report),
    .o_report_valid(phase_report_valid)
  );

  report_framer #(
    .T_PAYLOAD(amplitude_report_t),
    .P_HEADER (`IAGC_AMPLITUDE_HEADER)
  ) u_amp_framer (
    .i_clock        (i_clock),
    .i_arst_n       (i_arst_n),
    .i_payload      (amp_report),
    .i_payload_valid(amp_report_valid),
    .o_stream       (amp_stream),
    .i_ready        (amp_ready)
  );

  report_framer #(
    .T_PAYLOAD(phase_report_t),
    .P_HEADER (`IAGC_PHASE_HEADER)
  ) u_phase_framer (
    .i_clock        (i_clock),
    .i_arst_n       (i_arst_n),
    .i_payload      (phase_report),
    .i_payload_valid(phase_report_valid),
    .o_stream       (phase_stream),
    .i_ready        (phase_ready)
  );

  report_arbiter u_report_arbiter (
    .i_clock       (i_clock),
    .i_arst_n      (i_arst_n),
    .i_amp_stream  (amp_stream),
    .i_phase_stream(phase_stream),
    .o_amp_ready   (amp_ready),
    .o_phase_ready (phase_ready),
    .o_tx_valid    (tx_valid),
    .o_tx_data     (tx_data),
    .i_tx_ready    (tx_ready)
  );

  uart_tx #(
    .P_CLKS_PER_BIT(P_CLKS_PER_BIT)
  ) u_uart_tx (
    .i_clock (i_clock),
    .i_arst_n(i_arst_n),
    .i_valid (tx_valid),
    .i_data  (tx_data),
    .o_ready (tx_ready),
    .o_tx    (o_tx)
  );

endmodule

`default_nettype wire

// File: hw/uart_tx.sv
`timescale 1ns/100ps
`default_nettype none

`include "iagc_settings.svh"

module uart_tx #(
  parameter int P_CLKS_PER_BIT = `IAGC_CLKS_PER_BIT
) (
  input  logic                    i_clock,
  input  logic                    i_arst_n,
  input  logic                    i_valid,
  input  logic [`IAGC_BYTE_W-1:0] i_data,
  output logic                    o_ready,
  output logic                    o_tx
);

  localparam int CNT_W = $clog2(P_CLKS_PER_BIT + 1);
  // start, data bits, stop
  localparam int LAST_BIT = `IAGC_BYTE_W + 1;

  logic                    busy;
  logic [CNT_W-1:0]        clk_cnt;
  logic [3:0]              bit_idx;
  // data bits then stop bit, shifted out lsb first
  logic [`IAGC_BYTE_W:0]   shift_q;
  logic                    accept;
  logic                    bit_end;

  assign o_ready = ~busy;
  assign accept  = ~busy & i_valid;
  assign bit_end = busy && (clk_cnt == CNT_W'(P_CLKS_PER_BIT - 1));

  always_ff @(posedge i_clock or negedge i_arst_n) begin
    if (!i_arst_n) begin
      busy    <= 1'b0;
      clk_cnt <= '0;
      bit_idx <= '0;
      o_tx    <= 1'b1;
    end else if (accept) begin
      // start bit goes out next cycle
      busy    <= 1'b1;
      clk_cnt <= '0;
      bit_idx <= '0;
      o_tx    <= 1'b0;
    end else if (bit_end) begin
      clk_cnt <= '0;
      if (bit_idx == 4'(LAST_BIT)) begin
        // stop bit done, line back to idle
        busy <= 1'b0;
        o_tx <= 1'b1;
      end else begin
        bit_idx <= bit_idx + 1'b1;
        o_tx    <= shift_q[0];
      end
    end else if (busy) begin
      clk_cnt <= clk_cnt + 1'b1;
    end
  end

  always_ff @(posedge i_clock) begin
    if (accept) begin
      shift_q <= {1'b1, i_data};
    end else if (bit_end) begin
      shift_q <= {1'b1, shift_q[`IAGC_BYTE_W:1]};
    end
  end

endmodule

`default_nettype wire

// File: hw/report_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

`include "iagc_settings.svh"

module report_arbiter (
  input  logic                    i_clock,
  input  logic                    i_arst_n,
  input  iagc_pkg::byte_stream_t  i_amp_stream,
  input  iagc_pkg::byte_stream_t  i_phase_stream,
  output logic                    o_amp_ready,
  output logic                    o_phase_ready,
  output logic                    o_tx_valid,
  output logic [`IAGC_BYTE_W-1:0] o_tx_data,
  input  logic                    i_tx_ready
);
  import iagc_pkg::*;

  // grant_sel 0 amplitude, 1 phase
  logic         grant_valid;
  logic         grant_sel;
  // phase served last after reset, so amplitude goes first
  logic         last_served;
  logic         next_sel;
  logic         frame_done;
  byte_stream_t granted;

  assign granted = grant_sel ? i_phase_stream : i_amp_stream;

  // forward only the granted stream
  assign o_tx_valid    = grant_valid & granted.valid;
  assign o_tx_data     = granted.data;
  assign o_amp_ready   = grant_valid & ~grant_sel & i_tx_ready;
  assign o_phase_ready = grant_valid & grant_sel & i_tx_ready;

  assign frame_done = o_tx_valid & i_tx_ready & granted.last;

  // round robin when both request
  always_comb begin
    if (i_amp_stream.valid && i_phase_stream.valid) begin
      next_sel = ~last_served;
    end else begin
      next_sel = i_phase_stream.valid;
    end
  end

  always_ff @(posedge i_clock or negedge i_arst_n) begin
    if (!i_arst_n) begin
      grant_valid <= 1'b0;
      grant_sel   <= 1'b0;
      last_served <= 1'b1;
    end else if (!grant_valid) begin
      grant_valid <= i_amp_stream.valid | i_phase_stream.valid;
      grant_sel   <= next_sel;
    end else if (frame_done) begin
      // release after the whole frame
      grant_valid <= 1'b0;
      last_served <= grant_sel;
    end
  end

endmodule

`default_nettype wire

// File: hw/report_framer.sv
`timescale 1ns/100ps
`default_nettype none

`include "iagc_settings.svh"

module report_framer #(
  parameter type                     T_PAYLOAD = iagc_pkg::amplitude_report_t,
  parameter logic [`IAGC_BYTE_W-1:0] P_HEADER  = `IAGC_AMPLITUDE_HEADER
) (
  input  logic                   i_clock,
  input  logic                   i_arst_n,
  input  T_PAYLOAD               i_payload,
  input  logic                   i_payload_valid,
  output iagc_pkg::byte_stream_t o_stream,
  input  logic                   i_ready
);

  localparam int PAYLOAD_W = $bits(T_PAYLOAD);
  localparam int N_BYTES   = PAYLOAD_W / `IAGC_BYTE_W;
  // index 0 is the header, 1..N_BYTES the payload
  localparam int IDX_W     = $clog2(N_BYTES + 1);

  logic                 busy;
  logic [IDX_W-1:0]     idx;
  logic [PAYLOAD_W-1:0] payload_q;
  logic                 is_last;
  logic                 xfer;

  assign is_last = (idx == IDX_W'(N_BYTES));
  assign xfer    = busy & i_ready;

  // byte mux, msb of payload first
  always_comb begin
    o_stream.valid = busy;
    o_stream.last  = busy & is_last;
    if (idx == '0) begin
      o_stream.data = P_HEADER;
    end else begin
      o_stream.data = payload_q[`IAGC_BYTE_W * (N_BYTES - int'(idx)) +: `IAGC_BYTE_W];
    end
  end

  always_ff @(posedge i_clock or negedge i_arst_n) begin
    if (!i_arst_n) begin
      busy <= 1'b0;
      idx  <= '0;
    end else if (!busy) begin
      // reports arriving while busy are dropped
      busy <= i_payload_valid;
      idx  <= '0;
    end else if (xfer) begin
      if (is_last) begin
        busy <= 1'b0;
        idx  <= '0;
      end else begin
        idx <= idx + 1'b1;
      end
    end
  end

  // capture only when idle
  always_ff @(posedge i_clock) begin
    if (!busy && i_payload_valid) begin
      payload_q <= i_payload;
    end
  end

endmodule

`default_nettype wire

// File: hw/phase_detector.sv
`timescale 1ns/100ps
`default_nettype none

`include "iagc_settings.svh"

module phase_detector #(
  parameter int P_COUNT = `IAGC_PHASE_COUNT
) (
  input  logic                    i_clock,
  input  logic                    i_arst_n,
  input  iagc_pkg::sample_t       i_sample,
  output iagc_pkg::phase_report_t o_report,
  output logic                    o_report_valid
);
  import iagc_pkg::*;

  localparam int CNT_W   = $clog2(P_COUNT + 1);
  // count field is everything below the flag
  localparam int AGREE_W = $bits(phase_report_t) - 1;

  logic [CNT_W-1:0]   cnt;
  logic [AGREE_W-1:0] agree_cnt;
  logic               agree;
  logic               window_end;
  phase_report_t      report_d;

  // sign bits match, zero counts as positive
  assign agree = (i_sample.ref_data[`IAGC_CHANNEL_W-1] == i_sample.err_data[`IAGC_CHANNEL_W-1]);

  assign window_end = i_sample.valid && (cnt == CNT_W'(P_COUNT - 1));

  // final count includes this sample
  always_comb begin
    report_d.agree_count = agree_cnt + AGREE_W'(agree);
    // in phase when at least 3/4 agree
    report_d.in_phase    = (4 * int'(report_d.agree_count)) >= (3 * P_COUNT);
  end

  always_ff @(posedge i_clock or negedge i_arst_n) begin
    if (!i_arst_n) begin
      cnt            <= '0;
      agree_cnt      <= '0;
      o_report_valid <= 1'b0;
    end else begin
      o_report_valid <= window_end;
      if (window_end) begin
        cnt       <= '0;
        agree_cnt <= '0;
      end else if (i_sample.valid) begin
        cnt       <= cnt + 1'b1;
        agree_cnt <= report_d.agree_count;
      end
    end
  end

  always_ff @(posedge i_clock) begin
    if (window_end) begin
      o_report <= report_d;
    end
  end

endmodule

`default_nettype wire

// File: hw/amplitude_detector.sv
`timescale 1ns/100ps
`default_nettype none

`include "iagc_settings.svh"

module amplitude_detector #(
  parameter int P_COUNT = `IAGC_AMPLITUDE_COUNT
) (
  input  logic                        i_clock,
  input  logic                        i_arst_n,
  input  iagc_pkg::sample_t           i_sample,
  output iagc_pkg::amplitude_report_t o_report,
  output logic                        o_report_valid
);
  import iagc_pkg::*;

  localparam int CNT_W = $clog2(P_COUNT + 1);
  localparam logic [`IAGC_CHANNEL_W-1:0] MAG_SAT = {1'b0, {(`IAGC_CHANNEL_W - 1){1'b1}}};

  // abs value, most negative clips to full scale
  function automatic logic [`IAGC_CHANNEL_W-1:0] magnitude(
    input logic signed [`IAGC_CHANNEL_W-1:0] x
  );
    logic [`IAGC_CHANNEL_W-1:0] neg;
    neg = -x;
    if (!x[`IAGC_CHANNEL_W-1]) begin
      return x;
    end
    // negation overflowed
    if (neg[`IAGC_CHANNEL_W-1]) begin
      return MAG_SAT;
    end
    return neg;
  endfunction

  logic [CNT_W-1:0]  cnt;
  amplitude_report_t peak_q;
  amplitude_report_t peak_d;
  logic              window_end;

  // running maxima including the current sample
  always_comb begin
    peak_d.ref_peak = (magnitude(i_sample.ref_data) > peak_q.ref_peak) ?
                      magnitude(i_sample.ref_data) : peak_q.ref_peak;
    peak_d.err_peak = (magnitude(i_sample.err_data) > peak_q.err_peak) ?
                      magnitude(i_sample.err_data) : peak_q.err_peak;
  end

  assign window_end = i_sample.valid && (cnt == CNT_W'(P_COUNT - 1));

  always_ff @(posedge i_clock or negedge i_arst_n) begin
    if (!i_arst_n) begin
      cnt            <= '0;
      peak_q         <= '0;
      o_report_valid <= 1'b0;
    end else begin
      o_report_valid <= window_end;
      if (window_end) begin
        // start a fresh window
        cnt    <= '0;
        peak_q <= '0;
      end else if (i_sample.valid) begin
        cnt    <= cnt + 1'b1;
        peak_q <= peak_d;
      end
    end
  end

  // report held until the next window ends
  always_ff @(posedge i_clock) begin
    if (window_end) begin
      o_report <= peak_d;
    end
  end

endmodule

`default_nettype wire

// File: hw/adc_front.sv
`timescale 1ns/100ps
`default_nettype none

`include "iagc_settings.svh"

module adc_front (
  input  logic                    i_clock,
  input  logic                    i_arst_n,
  input  logic [`IAGC_WORD_W-1:0] i_adc_data,
  input  logic                    i_adc_data_valid,
  input  logic                    i_gate,
  output iagc_pkg::sample_t       o_sample
);

  // two-stage gate synchronizer
  logic                    gate_meta;
  logic                    gate_sync;
  // registered strobe and word
  logic                    strobe_q;
  logic [`IAGC_WORD_W-1:0] word_q;

  always_ff @(posedge i_clock or negedge i_arst_n) begin
    if (!i_arst_n) begin
      gate_meta <= 1'b0;
      gate_sync <= 1'b0;
      strobe_q  <= 1'b0;
    end else begin
      gate_meta <= i_gate;
      gate_sync <= gate_meta;
      strobe_q  <= i_adc_data_valid;
    end
  end

  // word only loads on a strobe
  always_ff @(posedge i_clock) begin
    if (i_adc_data_valid) begin
      word_q <= i_adc_data;
    end
  end

  // only gated samples count downstream
  assign o_sample.valid    = strobe_q & gate_sync;
  assign o_sample.ref_data = $signed(word_q[`IAGC_WORD_W-1 -: `IAGC_CHANNEL_W]);
  assign o_sample.err_data = $signed(word_q[`IAGC_CHANNEL_W-1:0]);

endmodule

`default_nettype wire

// File: hw/iagc_pkg.sv
`default_nettype none

`include "iagc_settings.svh"

package iagc_pkg;

  // one converter sample, both channels signed
  typedef struct packed {
    logic                              valid;
    logic signed [`IAGC_CHANNEL_W-1:0] ref_data;
    logic signed [`IAGC_CHANNEL_W-1:0] err_data;
  } sample_t;

  // peak magnitudes, ref goes out first
  typedef struct packed {
    logic [`IAGC_CHANNEL_W-1:0] ref_peak;
    logic [`IAGC_CHANNEL_W-1:0] err_peak;
  } amplitude_report_t;

  // flag in the top bit of the first payload byte
  typedef struct packed {
    logic        in_phase;
    logic [14:0] agree_count;
  } phase_report_t;

  // one byte of a frame with its handshake valid
  typedef struct packed {
    logic                    valid;
    logic [`IAGC_BYTE_W-1:0] data;
    logic                    last;
  } byte_stream_t;

endpackage

`default_nettype wire

// File: hw/iagc_settings.svh
`ifndef IAGC_SETTINGS_SVH
`define IAGC_SETTINGS_SVH

// sample widths
`define IAGC_CHANNEL_W 16
// ref channel in upper half, err channel in lower half
`define IAGC_WORD_W 32
`define IAGC_BYTE_W 8

// window lengths in gated samples
`define IAGC_AMPLITUDE_COUNT 256
`define IAGC_PHASE_COUNT 256

// serial line timing
`define IAGC_CLK_FREQ 100_000_000
`define IAGC_BAUDRATE 9_200
`define IAGC_CLKS_PER_BIT (`IAGC_CLK_FREQ / `IAGC_BAUDRATE)

// frame header bytes
`define IAGC_AMPLITUDE_HEADER 8'hA5
`define IAGC_PHASE_HEADER 8'h5A

`endif
